/* include/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// geometry
`define DC_SETS      256
`define DC_WORDS     4

// address fields
`define DC_INDEX_W   8
`define DC_TAG_W     20
`define DC_OFFSET_W  4

`define DC_WORD_W    32

`endif

/* src/bus_pkg.sv */
`include "dcache_config.svh"

package bus_pkg;

    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_WORD_W/8-1:0] wstrb_t;

    // word 0 sits in the low bits
    typedef logic [`DC_WORDS*`DC_WORD_W-1:0] line_t;

    typedef logic [`DC_TAG_W+`DC_INDEX_W+`DC_OFFSET_W-1:0] addr_t;

endpackage

/* src/cache_pkg.sv */
`include "dcache_config.svh"

package cache_pkg;

    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t; // [3:2] picks the word
    typedef logic                    way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,     // victim writeback if dirty
        REPLACE,  // line read request
        REFILL    // waiting for ret_valid
    } cache_state_e;

endpackage

/* src/tag_ram.sv */
`include "dcache_config.svh"

module tag_ram
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   wen,
    input  index_t addr,
    input  tag_t   wdata,
    output tag_t   rdata
);

    tag_t mem [`DC_SETS];

    // read data undefined on a write cycle
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

/* src/data_bank.sv */
`include "dcache_config.svh"

module data_bank
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic   clk,
    input  wstrb_t wen,
    input  index_t addr,
    input  word_t  wdata,
    output word_t  rdata
);

    word_t mem [`DC_SETS];

    always_ff @(posedge clk) begin
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            if (wen[b]) begin
                mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
        rdata <= mem[addr]; // old data on a write
    end

endmodule

/* src/way_state.sv */
`include "dcache_config.svh"

module way_state
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  index_t     rd_index,
    output logic [1:0] valid,
    output logic [1:0] dirty,
    output way_t       victim,
    input  logic       upd_en,
    input  index_t     upd_index,
    input  way_t       upd_way,
    input  logic       upd_fill,
    input  logic       upd_dirty
);

    logic [`DC_SETS-1:0][1:0] valid_q;
    logic [`DC_SETS-1:0][1:0] dirty_q;
    logic [`DC_SETS-1:0]      lru_q;   // next way to evict

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (upd_en) begin
            lru_q[upd_index] <= ~upd_way;
            if (upd_fill) begin
                valid_q[upd_index][upd_way] <= 1'b1;
                dirty_q[upd_index][upd_way] <= upd_dirty;
            end else if (upd_dirty) begin
                dirty_q[upd_index][upd_way] <= 1'b1; // store hit
            end
        end
    end

    assign valid  = valid_q[rd_index];
    assign dirty  = dirty_q[rd_index];
    assign victim = lru_q[rd_index];

endmodule

/* src/dcache.sv */
`include "dcache_config.svh"

module dcache
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    valid,
    input  logic    op,
    input  index_t  index,
    input  tag_t    tag,
    input  offset_t offset,
    input  wstrb_t  wstrb,
    input  word_t   wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  line_t   ret_data,
    output logic    wr_req,
    output addr_t   wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy
);

    cache_state_e state;
    cache_state_e state_nxt;

    // request buffer
    logic    op_q;
    index_t  index_q;
    tag_t    tag_q;
    offset_t offset_q;
    wstrb_t  wstrb_q;
    word_t   wdata_q;

    index_t     ram_addr;
    tag_t       way_tag [2];
    line_t      way_line [2];
    logic [1:0] way_valid;
    logic [1:0] way_dirty;
    logic [1:0] hit_vec;
    logic       hit;
    way_t       hit_way;
    way_t       victim;
    way_t       victim_q;
    logic       victim_dirty;
    logic       refill_en;
    logic       store_hit;
    line_t      fill_line;
    logic [1:0] word_sel;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                state_nxt = hit ? IDLE : MISS;
            end
            MISS: begin
                if (!victim_dirty || wr_rdy) begin
                    state_nxt = REPLACE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            op_q     <= op;
            index_q  <= index;
            tag_q    <= tag;
            offset_q <= offset;
            wstrb_q  <= wstrb;
            wdata_q  <= wdata;
        end
    end

    // victim is fixed once the miss is known
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            victim_q <= victim;
        end
    end

    assign word_sel  = offset_q[`DC_OFFSET_W-1:2];
    assign ram_addr  = (state == IDLE) ? index : index_q;
    assign hit       = |hit_vec;
    assign hit_way   = hit_vec[1];
    assign store_hit = (state == LOOKUP) && hit && op_q;
    assign refill_en = (state == REFILL) && ret_valid;

    assign victim_dirty = way_valid[victim_q] && way_dirty[victim_q];

    // store word merged over the returned line
    always_comb begin
        fill_line = ret_data;
        if (op_q) begin
            for (int b = 0; b < `DC_WORD_W/8; b++) begin
                if (wstrb_q[b]) begin
                    fill_line[word_sel*`DC_WORD_W + b*8 +: 8] = wdata_q[b*8 +: 8];
                end
            end
        end
    end

    assign addr_ok = (state == IDLE);
    assign data_ok = ((state == LOOKUP) && hit) || refill_en;
    assign rdata   = (state == REFILL) ? ret_data[word_sel*`DC_WORD_W +: `DC_WORD_W]
                                       : way_line[hit_way][word_sel*`DC_WORD_W +: `DC_WORD_W];

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {tag_q, index_q, {`DC_OFFSET_W{1'b0}}};
    assign wr_req  = (state == MISS) && victim_dirty;
    assign wr_addr = {way_tag[victim_q], index_q, {`DC_OFFSET_W{1'b0}}};
    assign wr_data = way_line[victim_q];

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic fill_wen;

        assign fill_wen   = refill_en && (victim_q == w);
        assign hit_vec[w] = way_valid[w] && (way_tag[w] == tag_q);

        tag_ram u_tag (
            .clk   (clk),
            .wen   (fill_wen),
            .addr  (ram_addr),
            .wdata (tag_q),
            .rdata (way_tag[w])
        );

        for (genvar k = 0; k < `DC_WORDS; k++) begin : g_bank
            wstrb_t bank_wen;
            word_t  bank_wdata;

            always_comb begin
                bank_wen = '0;
                if (fill_wen) begin
                    bank_wen = '1;
                end else if (store_hit && (hit_way == w) && (word_sel == k)) begin
                    bank_wen = wstrb_q;
                end
            end

            assign bank_wdata = (state == REFILL) ? fill_line[k*`DC_WORD_W +: `DC_WORD_W]
                                                  : wdata_q;

            data_bank u_bank (
                .clk   (clk),
                .wen   (bank_wen),
                .addr  (ram_addr),
                .wdata (bank_wdata),
                .rdata (way_line[w][k*`DC_WORD_W +: `DC_WORD_W])
            );
        end
    end

    way_state u_state (
        .clk       (clk),
        .resetn    (resetn),
        .rd_index  (index_q),
        .valid     (way_valid),
        .dirty     (way_dirty),
        .victim    (victim),
        .upd_en    (((state == LOOKUP) && hit) || refill_en),
        .upd_index (index_q),
        .upd_way   ((state == REFILL) ? victim_q : hit_way),
        .upd_fill  (state == REFILL),
        .upd_dirty (op_q)  // dirty on store, on hit or on fill
    );

endmodule

/* verif/tb_dcache.sv */
`include "dcache_config.svh"

module tb_dcache
    import bus_pkg::*;
    import cache_pkg::*;
();

    logic    clk = 1'b0;
    logic    resetn;
    logic    valid;
    logic    op;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    wstrb_t  wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    line_t   ret_data;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    // golden table with one entry per access
    logic   g_op [$];
    addr_t  g_addr [$];
    wstrb_t g_wstrb [$];
    word_t  g_wdata [$];
    word_t  g_exp [$];
    int     g_path [$];

    line_t mem [addr_t];  // backing store by line address
    word_t arch [addr_t]; // cpu view of stored words

    int unsigned lcg_state = 1;
    int    errors = 0;
    int    mem_errors = 0;
    int    rd_count = 0;
    int    wr_count = 0;
    int    passed = 0;
    int    failed = 0;
    addr_t last_rd_addr = '0;
    addr_t cur_addr = '0;
    bit    loaded = 1'b0;
    string cur_name = "reset state";

    dcache u_dut (.*);

    always #20 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // untouched words hold their own address xor a fixed pattern
    function automatic word_t arch_word(input addr_t a);
        if (arch.exists(a)) begin
            return arch[a];
        end
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic line_t model_line(input addr_t line_addr);
        line_t l;
        if (mem.exists(line_addr)) begin
            return mem[line_addr];
        end
        for (int k = 0; k < `DC_WORDS; k++) begin
            l[k*`DC_WORD_W +: `DC_WORD_W] = (line_addr + addr_t'(k * 4)) ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    task automatic check_writeback();
        word_t want;
        word_t got;
        // victim shares the set of the access but holds another tag
        if (wr_addr[`DC_OFFSET_W-1:0] != '0 ||
            wr_addr[`DC_OFFSET_W +: `DC_INDEX_W] != cur_addr[`DC_OFFSET_W +: `DC_INDEX_W] ||
            wr_addr[31:`DC_OFFSET_W+`DC_INDEX_W] == cur_addr[31:`DC_OFFSET_W+`DC_INDEX_W]) begin
            $display("%s: writeback address %h is not another line in the set of %h",
                     cur_name, wr_addr, cur_addr);
            mem_errors++;
        end
        for (int k = 0; k < `DC_WORDS; k++) begin
            want = arch_word(wr_addr + addr_t'(k * 4));
            got  = wr_data[k*`DC_WORD_W +: `DC_WORD_W];
            if (got !== want) begin
                $display("** Error %s: writeback word %h expected %h, actual %h",
                         cur_name, wr_addr + addr_t'(k * 4), want, got);
                mem_errors++;
            end
        end
    endtask

    // memory model driven on the falling edge
    initial begin
        int    ret_wait;
        bit    ret_pending;
        addr_t ret_addr;
        rd_rdy      = 1'b0;
        wr_rdy      = 1'b0;
        ret_valid   = 1'b0;
        ret_data    = '0;
        ret_wait    = 0;
        ret_pending = 1'b0;
        ret_addr    = '0;
        forever begin
            @(negedge clk);
            ret_valid = 1'b0;
            if (ret_pending) begin
                if (ret_wait == 0) begin
                    ret_valid   = 1'b1;
                    ret_data    = model_line(ret_addr);
                    ret_pending = 1'b0;
                end else begin
                    ret_wait--;
                end
            end
            rd_rdy = (lcg_next() % 2) != 0;
            wr_rdy = (lcg_next() % 2) != 0;
            if (rd_req && rd_rdy) begin // handshake on the coming edge
                rd_count++;
                last_rd_addr = rd_addr;
                ret_addr     = rd_addr;
                ret_pending  = 1'b1;
                ret_wait     = int'(lcg_next() % 4);
            end
            if (wr_req && wr_rdy) begin
                wr_count++;
                check_writeback();
                mem[wr_addr] = wr_data;
            end
        end
    end

    task automatic load_golden(output bit ok);
        int          fd;
        int          rc;
        string       text;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wstrb;
        logic [31:0] f_wdata;
        logic [31:0] f_exp;
        logic [31:0] f_path;
        ok = 1'b0;
        fd = $fopen("verif/dcache_golden.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(text, fd);
            if (rc > 1 && text.getc(0) != "#") begin
                rc = $sscanf(text, "%h %h %h %h %h %h",
                             f_op, f_addr, f_wstrb, f_wdata, f_exp, f_path);
                if (rc == 6) begin
                    g_op.push_back(f_op[0]);
                    g_addr.push_back(f_addr);
                    g_wstrb.push_back(f_wstrb[3:0]);
                    g_wdata.push_back(f_wdata);
                    g_exp.push_back(f_exp);
                    g_path.push_back(int'(f_path));
                end
            end
        end
        $fclose(fd);
        ok = (g_addr.size() > 0);
    endtask

    task automatic record_result(input int err0, input int merr0);
        if (errors == err0 && mem_errors == merr0) begin
            passed++;
            $display("%s: ok", cur_name);
        end else begin
            failed++;
            $display("%s: fail", cur_name);
        end
    endtask

    task automatic check_reset_state();
        int err0;
        err0 = errors;
        @(negedge clk);
        #10;
        if (addr_ok !== 1'b1) begin
            $display("** Error %s: addr_ok expected 1, actual %b", cur_name, addr_ok);
            errors++;
        end
        if ({data_ok, rd_req, wr_req} !== 3'b000) begin
            $display("** Error %s: data_ok rd_req wr_req expected 000, actual %b%b%b",
                     cur_name, data_ok, rd_req, wr_req);
            errors++;
        end
        record_result(err0, mem_errors);
    endtask

    task automatic run_access(input int i);
        addr_t a;
        word_t w;
        int    lat;
        int    rd0;
        int    wr0;
        int    err0;
        int    merr0;
        int    want_wb;
        a        = g_addr[i];
        cur_addr = a;
        cur_name = $sformatf("test %0d %s %h", i + 1, g_op[i] ? "write" : "read", a);
        err0     = errors;
        merr0    = mem_errors;
        want_wb  = (g_path[i] == 2) ? 1 : 0;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        rd0    = rd_count;
        wr0    = wr_count;
        valid  = 1'b1;
        op     = g_op[i];
        tag    = a[`DC_OFFSET_W+`DC_INDEX_W +: `DC_TAG_W];
        index  = a[`DC_OFFSET_W +: `DC_INDEX_W];
        offset = a[`DC_OFFSET_W-1:0];
        wstrb  = g_wstrb[i];
        wdata  = g_wdata[i];
        @(negedge clk);
        valid = 1'b0;
        lat   = 1;
        #10; // ret_valid has settled by now
        while (!data_ok) begin
            @(negedge clk);
            lat++;
            #10;
        end
        if (addr_ok !== 1'b0) begin
            $display("** Error %s: addr_ok at data_ok expected 0, actual %b", cur_name, addr_ok);
            errors++;
        end
        if (!g_op[i] && rdata !== g_exp[i]) begin
            $display("** Error %s: expected %h, actual %h", cur_name, g_exp[i], rdata);
            errors++;
        end
        if (g_path[i] == 1) begin
            if (lat != 1) begin
                $display("** Error %s: hit latency expected 1, actual %0d", cur_name, lat);
                errors++;
            end
            if (rd_count != rd0) begin
                $display("%s: a line was fetched although the access should hit", cur_name);
                errors++;
            end
        end else if (rd_count - rd0 != 1) begin
            $display("** Error %s: line fetches expected 1, actual %0d", cur_name, rd_count - rd0);
            errors++;
        end else if (last_rd_addr !== {a[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}}) begin
            $display("** Error %s: rd_addr expected %h, actual %h", cur_name,
                     {a[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}}, last_rd_addr);
            errors++;
        end
        if (wr_count - wr0 != want_wb) begin
            $display("** Error %s: writebacks expected %0d, actual %0d",
                     cur_name, want_wb, wr_count - wr0);
            errors++;
        end
        if (g_op[i]) begin
            w = arch_word({a[31:2], 2'b00});
            for (int b = 0; b < 4; b++) begin
                if (g_wstrb[i][b]) begin
                    w[b*8 +: 8] = g_wdata[i][b*8 +: 8];
                end
            end
            arch[{a[31:2], 2'b00}] = w;
        end
        record_result(err0, merr0);
    endtask

    initial begin
        bit ok;
        resetn = 1'b1;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        load_golden(ok);
        if (!ok) begin
            $display("could not read any access from verif/dcache_golden.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (4) @(negedge clk);
            resetn = 1'b0;
            check_reset_state();
            for (int i = 0; i < g_addr.size(); i++) begin
                run_access(i);
            end
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     passed + failed, passed, failed, errors + mem_errors);
            if (failed == 0 && errors + mem_errors == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

    // watchdog sized from the number of accesses
    initial begin
        int cycles;
        wait (loaded);
        cycles = g_addr.size() * 40 + 100;
        #(cycles * 40);
        $display("timeout: the accesses did not finish within %0d clock cycles", cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
src/bus_pkg.sv
src/cache_pkg.sv
src/tag_ram.sv
src/data_bank.sv
src/way_state.sv
src/dcache.sv
verif/tb_dcache.sv

/* run.sh */
#!/bin/sh
# build the dcache testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f flist.f --top-module tb_dcache -o tb_dcache_sim &&
./obj_dir/tb_dcache_sim | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verif/dcache_golden.txt */
# op addr wstrb wdata expected path (all hex)
# op 1 = write, expected unused for writes; path 0 = miss, 1 = hit, 2 = miss with dirty writeback
0 00001104 0 00000000 A5A51104 0
0 00001104 0 00000000 A5A51104 1
0 0000110C 0 00000000 A5A5110C 1
1 00001108 3 DEADBEEF 00000000 1
0 00001108 0 00000000 A5A5BEEF 1
1 00002104 C 12345678 00000000 0
0 00002104 0 00000000 12342104 1
0 00003100 0 00000000 A5A53100 2
0 00001108 0 00000000 A5A5BEEF 2
0 0000A200 0 00000000 A5A5A200 0
0 0000B204 0 00000000 A5A5B204 0
0 0000A208 0 00000000 A5A5A208 1
0 0000C20C 0 00000000 A5A5C20C 0
0 0000A200 0 00000000 A5A5A200 1
0 0000B204 0 00000000 A5A5B204 0
0 00002104 0 00000000 12342104 0
1 00003100 F CAFEF00D 00000000 0
1 0000310C 1 000000AA 00000000 1
0 00002104 0 00000000 12342104 1
0 00004104 0 00000000 A5A54104 2
0 00003100 0 00000000 CAFEF00D 0
0 0000310C 0 00000000 A5A531AA 1
1 FFFFFFF0 F 0BADC0DE 00000000 0
0 FFFFFFF0 0 00000000 0BADC0DE 1
0 FFFFFFF4 0 00000000 5A5AFFF4 1
